// ==== rtl/cam_params.svh ====
`ifndef CAM_PARAMS_SVH
`define CAM_PARAMS_SVH

//////////////////////////////
// camera bring-up timing
//////////////////////////////
`define CAM_RST_CYCLES   256      // cam_rst_n low time after start.
`define CAM_DELAY_CYCLES 2000     // wait marker length, shortened for simulation.

//////////////////////////////
// sccb bus
//////////////////////////////
`define SCCB_QUARTER     25       // clocks per quarter scl period.
`define CAM_DEV_ADDR     8'h42    // ov7670 write address.

//////////////////////////////
// register table
//////////////////////////////
`define CMD_WAIT         16'hFFF0 // delay marker.
`define CMD_END          16'hFFFF // end of table.
`define CMD_DEPTH        16       // rom entries.

`endif

// ==== rtl/cam_pkg.sv ====
package cam_pkg;

  //////////////////////////////
  // register table
  //////////////////////////////

  // high byte is the register address, low byte the value.
  typedef logic [15:0] cmd_word_t;

  typedef logic [3:0] cmd_addr_t;  // rom index.

  // shared by the reset hold and the wait-marker delay.
  typedef logic [15:0] delay_cnt_t;

  //////////////////////////////
  // sequencer
  //////////////////////////////

  typedef enum logic [2:0] {
    SEQ_IDLE,   // waiting for start.
    SEQ_RESET,  // camera held in reset.
    SEQ_FETCH,  // reading the next table entry.
    SEQ_WAIT,   // wait marker delay.
    SEQ_WRITE,  // bus transaction in flight.
    SEQ_DONE,   // table finished.
    SEQ_ERROR   // a byte was not acknowledged.
  } seq_state_t;

endpackage

// ==== rtl/sccb_pkg.sv ====
package sccb_pkg;

  //////////////////////////////
  // bus data
  //////////////////////////////

  typedef logic [7:0] sccb_byte_t;

  // one register write; the device address is added by the engine.
  typedef struct packed {
    sccb_byte_t reg_addr;
    sccb_byte_t data;
  } sccb_cmd_t;

  // bit n covers byte n of the transaction, 1 is a nack.
  typedef logic [2:0] ack_t;

  //////////////////////////////
  // bus engine
  //////////////////////////////

  typedef logic [7:0] quarter_cnt_t;  // clocks within one quarter period.

  typedef enum logic [2:0] {
    PH_IDLE,   // both lines released.
    PH_START,  // sda falls while scl is high.
    PH_BITS,   // data bits, msb first.
    PH_ACK,    // sda released for the camera.
    PH_STOP    // sda rises while scl is high.
  } sccb_phase_t;

endpackage

// ==== rtl/cmd_rom.sv ====
`timescale 1ns/1ps

`include "cam_params.svh"

module cmd_rom (
  input  logic                clk,
  input  cam_pkg::cmd_addr_t  rom_addr,
  output cam_pkg::cmd_word_t  rom_data
);

  //////////////////////////////
  // ov7670 init list
  //////////////////////////////

  always_ff @(posedge clk) begin
    case (rom_addr)
      4'd0:    rom_data <= 16'h1280;    // com7, soft reset of all registers.
      4'd1:    rom_data <= `CMD_WAIT;   // let the camera settle.
      4'd2:    rom_data <= 16'h1204;    // com7, rgb output.
      4'd3:    rom_data <= 16'h1101;    // clkrc, divide input clock by 2.
      4'd4:    rom_data <= 16'h0C00;    // com3, no scaling.
      4'd5:    rom_data <= 16'h3E00;    // com14, normal pclk.
      4'd6:    rom_data <= 16'h8C00;    // rgb444 off.
      4'd7:    rom_data <= 16'h0400;    // com1, no ccir656.
      4'd8:    rom_data <= 16'h40D0;    // com15, rgb565 full range.
      4'd9:    rom_data <= 16'h3A04;    // tslb, fixed uv order.
      default: rom_data <= `CMD_END;    // index 10 and the spare slots end the walk.
    endcase
  end

endmodule

// ==== rtl/cfg_sequencer.sv ====
`timescale 1ns/1ps

`include "cam_params.svh"

module cfg_sequencer (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 start,
  output cam_pkg::cmd_addr_t   rom_addr,
  input  cam_pkg::cmd_word_t   rom_data,
  output sccb_pkg::sccb_cmd_t  cmd,
  output logic                 cmd_valid,
  input  logic                 cmd_done,
  input  sccb_pkg::ack_t       ack,
  output logic                 cam_rst_n,
  output cam_pkg::seq_state_t  cfg_state,
  output logic                 done,
  output logic                 err
);

  cam_pkg::seq_state_t state;
  cam_pkg::delay_cnt_t cnt;
  cam_pkg::cmd_addr_t  next_addr;
  logic                fetch_vld;  // rom_data matches rom_addr.
  logic                is_wait;
  logic                is_end;
  logic                issue;

  //////////////////////////////
  // table entry decode
  //////////////////////////////

  assign is_wait = (rom_data == `CMD_WAIT);
  assign is_end  = (rom_data == `CMD_END);
  assign issue   = (state == cam_pkg::SEQ_FETCH) && fetch_vld && !is_wait && !is_end;

  // the walk stops at the last slot.
  assign next_addr = (rom_addr == cam_pkg::cmd_addr_t'(`CMD_DEPTH - 1)) ? rom_addr
                                                                        : rom_addr + 1'b1;

  assign cfg_state = state;

  //////////////////////////////
  // control FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= cam_pkg::SEQ_IDLE;
      rom_addr  <= '0;
      cnt       <= '0;
      fetch_vld <= 1'b0;
      cmd_valid <= 1'b0;
      cam_rst_n <= 1'b0;
      done      <= 1'b0;
      err       <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      case (state)
        cam_pkg::SEQ_IDLE: begin
          if (start) begin
            state <= cam_pkg::SEQ_RESET;
            cnt   <= '0;
          end
        end
        cam_pkg::SEQ_RESET: begin
          cnt <= cnt + 1'b1;
          if (cnt == cam_pkg::delay_cnt_t'(`CAM_RST_CYCLES - 1)) begin
            cam_rst_n <= 1'b1;                 // release on the edge that ends the hold.
            state     <= cam_pkg::SEQ_FETCH;
            fetch_vld <= 1'b0;
          end
        end
        cam_pkg::SEQ_FETCH: begin
          if (!fetch_vld) begin
            fetch_vld <= 1'b1;                 // rom output lands this edge.
          end else if (is_end) begin
            state <= cam_pkg::SEQ_DONE;
            done  <= 1'b1;
          end else if (is_wait) begin
            state    <= cam_pkg::SEQ_WAIT;
            cnt      <= '0;
            rom_addr <= next_addr;
          end else begin
            state     <= cam_pkg::SEQ_WRITE;
            cmd_valid <= 1'b1;
            rom_addr  <= next_addr;            // next entry is read during the write.
          end
        end
        cam_pkg::SEQ_WAIT: begin
          cnt <= cnt + 1'b1;
          if (cnt == cam_pkg::delay_cnt_t'(`CAM_DELAY_CYCLES - 1)) begin
            state     <= cam_pkg::SEQ_FETCH;
            fetch_vld <= 1'b0;
          end
        end
        cam_pkg::SEQ_WRITE: begin
          if (cmd_done) begin
            if (|ack) begin
              state <= cam_pkg::SEQ_ERROR;
              err   <= 1'b1;
            end else begin
              state     <= cam_pkg::SEQ_FETCH;
              fetch_vld <= 1'b0;
            end
          end
        end
        default: begin
          // done and error hold until reset.
        end
      endcase
    end
  end

  // write payload, held for the whole transaction.
  always_ff @(posedge clk) begin
    if (issue) begin
      cmd.reg_addr <= rom_data[15:8];
      cmd.data     <= rom_data[7:0];
    end
  end

endmodule

// ==== rtl/sccb_master.sv ====
`timescale 1ns/1ps

`include "cam_params.svh"

module sccb_master (
  input  logic                 clk,
  input  logic                 arst_n,
  input  sccb_pkg::sccb_cmd_t  cmd,
  input  logic                 cmd_valid,
  output logic                 cmd_done,
  output sccb_pkg::ack_t       ack,
  output logic                 scl_oe,
  output logic                 sda_oe,
  input  logic                 sda_in
);

  sccb_pkg::sccb_phase_t  phase;
  sccb_pkg::quarter_cnt_t qcnt;
  sccb_pkg::sccb_byte_t   cur_byte;
  logic [1:0]             q;         // quarter within the scl period.
  logic [1:0]             byte_idx;
  logic [2:0]             bit_idx;
  logic                   tick;
  logic                   scl_nx;
  logic                   sda_nx;

  assign tick = (qcnt == sccb_pkg::quarter_cnt_t'(`SCCB_QUARTER - 1));

  always_comb begin
    case (byte_idx)
      2'd0:    cur_byte = `CAM_DEV_ADDR;
      2'd1:    cur_byte = cmd.reg_addr;
      default: cur_byte = cmd.data;
    endcase
  end

  //////////////////////////////
  // line levels per quarter
  //////////////////////////////

  // oe high pulls the line low. sda only moves in q0 while scl is low.
  always_comb begin
    scl_nx = 1'b0;
    sda_nx = 1'b0;
    case (phase)
      sccb_pkg::PH_START: begin
        sda_nx = (q != 2'd0);
        scl_nx = (q == 2'd3);
      end
      sccb_pkg::PH_BITS: begin
        sda_nx = !cur_byte[bit_idx];
        scl_nx = (q == 2'd0) || (q == 2'd3);
      end
      sccb_pkg::PH_ACK: begin
        scl_nx = (q == 2'd0) || (q == 2'd3);
      end
      sccb_pkg::PH_STOP: begin
        sda_nx = (q < 2'd2);
        scl_nx = (q == 2'd0);
      end
      default: begin
      end
    endcase
  end

  //////////////////////////////
  // phase machine
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase    <= sccb_pkg::PH_IDLE;
      qcnt     <= '0;
      q        <= '0;
      byte_idx <= '0;
      bit_idx  <= '0;
      ack      <= '0;
      cmd_done <= 1'b0;
      scl_oe   <= 1'b0;
      sda_oe   <= 1'b0;
    end else begin
      cmd_done <= 1'b0;
      scl_oe   <= scl_nx;
      sda_oe   <= sda_nx;
      if (phase == sccb_pkg::PH_IDLE) begin
        qcnt <= '0;
        q    <= '0;
        if (cmd_valid) begin
          phase    <= sccb_pkg::PH_START;
          byte_idx <= '0;
          bit_idx  <= 3'd7;
          ack      <= '0;
        end
      end else if (!tick) begin
        qcnt <= qcnt + 1'b1;
      end else begin
        qcnt <= '0;
        q    <= q + 1'b1;
        case (phase)
          sccb_pkg::PH_START: begin
            if (q == 2'd3) phase <= sccb_pkg::PH_BITS;
          end
          sccb_pkg::PH_BITS: begin
            if (q == 2'd3) begin
              if (bit_idx == 3'd0) phase <= sccb_pkg::PH_ACK;
              else bit_idx <= bit_idx - 1'b1;
            end
          end
          sccb_pkg::PH_ACK: begin
            if (q == 2'd1) ack[byte_idx] <= sda_in;  // middle of scl high, released sda is a nack.
            if (q == 2'd3) begin
              if (byte_idx == 2'd2) begin
                phase <= sccb_pkg::PH_STOP;
              end else begin
                phase    <= sccb_pkg::PH_BITS;
                byte_idx <= byte_idx + 1'b1;
                bit_idx  <= 3'd7;
              end
            end
          end
          default: begin
            if (q == 2'd3) begin
              phase    <= sccb_pkg::PH_IDLE;
              cmd_done <= 1'b1;
            end
          end
        endcase
      end
    end
  end

endmodule

// ==== rtl/cam_cfg_top.sv ====
`timescale 1ns/1ps

module cam_cfg_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 start,
  input  logic                 sda_in,
  output logic                 cam_rst_n,
  output logic                 scl_oe,
  output logic                 sda_oe,
  output logic                 done,
  output logic                 err,
  output cam_pkg::seq_state_t  cfg_state
);

  cam_pkg::cmd_addr_t  rom_addr;
  cam_pkg::cmd_word_t  rom_data;
  sccb_pkg::sccb_cmd_t cmd;
  sccb_pkg::ack_t      ack;
  logic                cmd_valid;
  logic                cmd_done;

  //////////////////////////////
  // rom -> sequencer -> bus
  //////////////////////////////

  cmd_rom cmd_rom_i (
    .clk      (clk),
    .rom_addr (rom_addr),
    .rom_data (rom_data)
  );

  cfg_sequencer cfg_sequencer_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .rom_addr  (rom_addr),
    .rom_data  (rom_data),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_done  (cmd_done),
    .ack       (ack),
    .cam_rst_n (cam_rst_n),
    .cfg_state (cfg_state),
    .done      (done),
    .err       (err)
  );

  sccb_master sccb_master_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_done  (cmd_done),
    .ack       (ack),
    .scl_oe    (scl_oe),
    .sda_oe    (sda_oe),
    .sda_in    (sda_in)
  );

endmodule

// ==== test/sccb_slave_model.sv ====
`timescale 1ns/1ps

module sccb_slave_model (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 scl,
  input  logic                 sda,
  input  logic                 nack_en,
  input  int                   nack_txn,   // transaction to refuse.
  input  int                   nack_byte,  // 0 is the device address.
  output logic                 sda_oe,
  output logic                 bus_start,
  output logic                 bus_stop,
  output logic                 rx_stb,     // fully acknowledged write.
  output sccb_pkg::sccb_byte_t rx_dev,
  output sccb_pkg::sccb_cmd_t  rx_cmd
);

  logic                 scl_q;
  logic                 sda_q;
  logic                 acked_all;
  logic                 refuse;
  sccb_pkg::sccb_byte_t shreg;
  int                   bit_cnt;
  int                   byte_cnt;
  int                   txn_cnt;

  assign refuse = nack_en && (txn_cnt == nack_txn) && (byte_cnt == nack_byte);

  // lines are sampled on the clock, so every reaction lags one cycle.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      scl_q     <= 1'b1;
      sda_q     <= 1'b1;
      sda_oe    <= 1'b0;
      bus_start <= 1'b0;
      bus_stop  <= 1'b0;
      rx_stb    <= 1'b0;
      rx_dev    <= '0;
      rx_cmd    <= '0;
      shreg     <= '0;
      acked_all <= 1'b0;
      bit_cnt   <= 0;
      byte_cnt  <= 0;
      txn_cnt   <= 0;
    end else begin
      scl_q     <= scl;
      sda_q     <= sda;
      bus_start <= 1'b0;
      bus_stop  <= 1'b0;
      rx_stb    <= 1'b0;
      if (scl && scl_q && sda_q && !sda) begin
        bus_start <= 1'b1;                    // sda fell with scl high.
        bit_cnt   <= 0;
        byte_cnt  <= 0;
        acked_all <= 1'b1;
      end else if (scl && scl_q && !sda_q && sda) begin
        bus_stop <= 1'b1;
        txn_cnt  <= txn_cnt + 1;
        rx_stb   <= acked_all && (byte_cnt == 3);
      end else if (scl && !scl_q && bit_cnt < 8) begin
        shreg   <= {shreg[6:0], sda};
        bit_cnt <= bit_cnt + 1;
      end else if (!scl && scl_q && bit_cnt == 8) begin
        case (byte_cnt)
          0:       rx_dev          <= shreg;
          1:       rx_cmd.reg_addr <= shreg;
          default: rx_cmd.data     <= shreg;
        endcase
        sda_oe  <= !refuse;                   // ack slot opens.
        bit_cnt <= 9;
        if (refuse) acked_all <= 1'b0;
      end else if (!scl && scl_q && bit_cnt == 9) begin
        sda_oe   <= 1'b0;
        bit_cnt  <= 0;
        byte_cnt <= byte_cnt + 1;
      end
    end
  end

endmodule

// ==== test/cam_cfg_assertions.sv ====
`timescale 1ns/1ps

module cam_cfg_assertions (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  scl_oe,
  input logic                  sda_oe,
  input logic                  sda_in,
  input logic                  done,
  input logic                  err,
  input logic                  cmd_valid,
  input cam_pkg::seq_state_t   cfg_state,
  input sccb_pkg::sccb_phase_t phase
);

  int fails = 0;  // failed checks so far.

  //////////////////////////////
  // bus protocol
  //////////////////////////////

  // only the master drives scl, so !scl_oe is the line.
  sda_moves_scl_low: assert property (@(posedge clk) disable iff (!arst_n)
    (!scl_oe && $past(!scl_oe) && $changed(sda_in)) |->
      (phase == sccb_pkg::PH_START || phase == sccb_pkg::PH_STOP))
    else begin fails++; $error("sda moved while scl was high"); end

  bus_idle_in_reset: assert property (@(posedge clk) disable iff (!arst_n)
    (cfg_state == cam_pkg::SEQ_IDLE || cfg_state == cam_pkg::SEQ_RESET) |->
      (!scl_oe && !sda_oe))
    else begin fails++; $error("bus driven before the camera left reset"); end

  cmd_only_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
    cmd_valid |-> (phase == sccb_pkg::PH_IDLE))
    else begin fails++; $error("write issued to a busy bus engine"); end

  //////////////////////////////
  // status
  //////////////////////////////

  done_err_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(done && err))
    else begin fails++; $error("done and err high together"); end

  quiet_after_done: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> (!scl_oe && !sda_oe))
    else begin fails++; $error("bus activity after done"); end

endmodule

// ==== test/tb_cam_cfg.sv ====
`timescale 1ns/1ps

`include "cam_params.svh"

module tb_cam_cfg;

  logic                 clk = 1'b0;
  logic                 arst_n;
  logic                 start;
  logic                 cam_rst_n;
  logic                 scl_oe;
  logic                 sda_oe;
  logic                 done;
  logic                 err;
  cam_pkg::seq_state_t  cfg_state;
  logic                 scl;
  logic                 sda;
  logic                 model_sda_oe;
  logic                 nack_en;
  int                   nack_txn;
  int                   nack_byte;
  logic                 bus_start;
  logic                 bus_stop;
  logic                 rx_stb;
  sccb_pkg::sccb_byte_t rx_dev;
  sccb_pkg::sccb_cmd_t  rx_cmd;
  logic [15:0]          lfsr_state;
  cam_pkg::cmd_word_t   exp_q[$];
  logic                 after_wait[$];     // write follows a wait marker.
  sccb_pkg::sccb_byte_t rx_dev_q[$];
  sccb_pkg::sccb_cmd_t  rx_cmd_q[$];
  int                   starts;
  int                   cyc;
  int                   last_stop;

  cam_pkg::cmd_word_t table_ref [0:10] = '{16'h1280, `CMD_WAIT, 16'h1204, 16'h1101,
    16'h0C00, 16'h3E00, 16'h8C00, 16'h0400, 16'h40D0, 16'h3A04, `CMD_END};

  always #20 clk = ~clk;

  assign scl = !scl_oe;                    // pull-ups on both lines.
  assign sda = !(sda_oe || model_sda_oe);

  cam_cfg_top cam_cfg_top_i (
    .clk(clk), .arst_n(arst_n), .start(start), .sda_in(sda), .cam_rst_n(cam_rst_n),
    .scl_oe(scl_oe), .sda_oe(sda_oe), .done(done), .err(err), .cfg_state(cfg_state)
  );

  sccb_slave_model sccb_slave_model_i (
    .clk(clk), .arst_n(arst_n), .scl(scl), .sda(sda), .nack_en(nack_en),
    .nack_txn(nack_txn), .nack_byte(nack_byte), .sda_oe(model_sda_oe),
    .bus_start(bus_start), .bus_stop(bus_stop), .rx_stb(rx_stb), .rx_dev(rx_dev),
    .rx_cmd(rx_cmd)
  );

  bind cam_cfg_top cam_cfg_assertions cam_cfg_assertions_i (
    .clk(clk), .arst_n(arst_n), .scl_oe(scl_oe), .sda_oe(sda_oe), .sda_in(sda_in),
    .done(done), .err(err), .cmd_valid(cmd_valid), .cfg_state(cfg_state),
    .phase(sccb_master_i.phase)
  );

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_val(input string name, input int exp, input int act);
    assert (act == exp) else begin
      $display("Fail at %0t ns: %s expected 'h%0h, actual 'h%0h", $time, name, exp, act);
      fail_now("value mismatch");
    end
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    arst_n <= 1'b0;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    repeat (4) @(negedge clk);
    check_val("cam_rst_n", 0, int'(cam_rst_n));
    check_val("scl_oe", 0, int'(scl_oe));
    check_val("sda_oe", 0, int'(sda_oe));
    check_val("done", 0, int'(done));
    check_val("err", 0, int'(err));
    check_val("cfg_state", int'(cam_pkg::SEQ_IDLE), int'(cfg_state));
  endtask

  // pulse start and count cycles until the camera leaves reset.
  task automatic release_camera();
    int n;
    n = 0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    while (!cam_rst_n) begin
      n++;
      if (n > 2 * `CAM_RST_CYCLES) fail_now("timeout waiting for cam_rst_n to rise");
      @(negedge clk);
    end
    check_val("cam_rst_n release cycles", `CAM_RST_CYCLES, n);
  endtask

  task automatic wait_end(input int limit);
    int n;
    n = 0;
    while (!done && !err) begin
      n++;
      if (n > limit) fail_now("timeout waiting for done or err");
      @(negedge clk);
    end
  endtask

  //////////////////////////////
  // bus monitor
  //////////////////////////////

  always @(negedge clk) begin
    if (!arst_n) begin
      starts    = 0;
      cyc       = 0;
      last_stop = 0;
      rx_dev_q.delete();
      rx_cmd_q.delete();
    end else begin
      cyc++;
      if (bus_start) begin
        assert (cam_rst_n) else fail_now("bus start condition while camera in reset");
        assert (!(starts < after_wait.size() && after_wait[starts] &&
                  cyc - last_stop < `CAM_DELAY_CYCLES))
          else fail_now("write after the wait marker started too early");
        starts++;
      end
      if (bus_stop) last_stop = cyc;
      if (rx_stb) begin
        rx_dev_q.push_back(rx_dev);
        rx_cmd_q.push_back(rx_cmd);
      end
    end
    assert (cam_cfg_top_i.cam_cfg_assertions_i.fails == 0)
      else fail_now("a bound protocol or status assertion failed");
  end

  initial begin
    logic gap_next;
    int   v;
    arst_n     = 1'b0;
    start      = 1'b0;
    nack_en    = 1'b0;
    nack_txn   = 0;
    nack_byte  = 0;
    lfsr_state = 16'd12026;
    gap_next   = 1'b0;
    for (int i = 0; i < 11; i++) begin
      if (table_ref[i] == `CMD_END) break;
      if (table_ref[i] == `CMD_WAIT) begin
        gap_next = 1'b1;
      end else begin
        exp_q.push_back(table_ref[i]);
        after_wait.push_back(gap_next);
        gap_next = 1'b0;
      end
    end

    // every byte acknowledged.
    apply_reset();
    release_camera();
    wait_end(100000);
    check_val("done", 1, int'(done));
    check_val("err", 0, int'(err));
    check_val("cfg_state", int'(cam_pkg::SEQ_DONE), int'(cfg_state));
    check_val("received writes", exp_q.size(), rx_cmd_q.size());
    for (int i = 0; i < exp_q.size(); i++) begin
      check_val("rx_dev", int'(`CAM_DEV_ADDR), int'(rx_dev_q[i]));
      check_val("rx_reg", int'(exp_q[i][15:8]), int'(rx_cmd_q[i].reg_addr));
      check_val("rx_data", int'(exp_q[i][7:0]), int'(rx_cmd_q[i].data));
    end
    repeat (1000) @(negedge clk);
    check_val("bus starts", exp_q.size(), starts);

    // second run, one byte refused.
    take_bits(4, v);
    nack_txn = v % exp_q.size();
    take_bits(2, v);
    nack_byte = v % 3;
    nack_en   = 1'b1;
    apply_reset();
    release_camera();
    wait_end(100000);
    check_val("err", 1, int'(err));
    check_val("done", 0, int'(done));
    check_val("cfg_state", int'(cam_pkg::SEQ_ERROR), int'(cfg_state));
    check_val("accepted writes", nack_txn, rx_cmd_q.size());
    repeat (1000) @(negedge clk);
    check_val("bus starts", nack_txn + 1, starts);

    if (cam_cfg_top_i.cam_cfg_assertions_i.fails == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      fail_now("a bound protocol or status assertion failed");
    end
  end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/cam_pkg.sv
rtl/sccb_pkg.sv
rtl/cmd_rom.sv
rtl/cfg_sequencer.sv
rtl/sccb_master.sv
rtl/cam_cfg_top.sv
test/sccb_slave_model.sv
test/cam_cfg_assertions.sv
test/tb_cam_cfg.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  -f verilog.f --top-module tb_cam_cfg -o Vtb_cam_cfg

run: compile
	./obj_dir/Vtb_cam_cfg +verilator+error+limit+100

clean:
	rm -rf obj_dir
